/* tb.f */
rtl/lsu_pkg.sv
rtl/lsu.sv
rtl/ls_ctrl.sv
rtl/data_sram.sv
rtl/ls_unit_top.sv
testbench/ls_unit_props.sv
testbench/tb_ls_unit.sv

/* Makefile */
# Verilator build and run of the load/store unit testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the simulation into sim.log and check it"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --assert --top-module tb_ls_unit -f tb.f -Mdir obj_dir
	./obj_dir/Vtb_ls_unit > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "STATUS: FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "STATUS: PASS" sim.log; then echo "simulation ended early"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log

/* testbench/tb_ls_unit.sv */
`timescale 1ns/100ps

module tb_ls_unit;

    localparam int DEPTH     = 256;
    localparam int XLEN      = lsu_pkg::XLEN;
    localparam int MEM_BYTES = DEPTH * 8;
    localparam int AW        = $clog2(MEM_BYTES);

    logic             clk;
    logic             rst_i;
    logic             start_i;
    logic             we_i;
    lsu_pkg::mem_op_e op_i;
    logic [XLEN-1:0]  addr_i;
    logic [XLEN-1:0]  wdata_i;
    logic             busy_o;
    logic             done_o;
    logic             err_o;
    logic [XLEN-1:0]  rdata_o;

    // byte-wide model of the sram that wraps the same way
    logic [7:0] shadow [MEM_BYTES];
    // error counts per test and over the whole run
    int test_errs;
    int total_errs;
    int tests_ok;
    int tests_bad;

    ls_unit_top #(
        .SRAM_DEPTH (DEPTH)
    ) ls_unit_top_i (
        .clk     (clk),
        .rst_i   (rst_i),
        .start_i (start_i),
        .we_i    (we_i),
        .op_i    (op_i),
        .addr_i  (addr_i),
        .wdata_i (wdata_i),
        .busy_o  (busy_o),
        .done_o  (done_o),
        .err_o   (err_o),
        .rdata_o (rdata_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // misaligned for its width or a store with a zero-extend op
    function automatic logic access_illegal(input logic we, input lsu_pkg::mem_op_e op,
                                            input logic [XLEN-1:0] addr);
        int n;
        n = 1 << op[1:0];
        return (int'(addr[2:0]) % n != 0) || (we && op[2]) || (op == 3'd7);
    endfunction

    function automatic logic [XLEN-1:0] expect_load(input lsu_pkg::mem_op_e op,
                                                   input logic [XLEN-1:0] addr);
        logic [XLEN-1:0] val;
        int n;
        int base;
        n    = 1 << op[1:0];
        base = int'(addr[AW-1:0]);
        val  = '0;
        for (int i = 0; i < n; i++) begin
            val[i*8 +: 8] = shadow[base + i];
        end
        // sign fill above the loaded lanes unless zero-extending
        if (!op[2] && val[n*8-1]) begin
            for (int i = n * 8; i < XLEN; i++) begin
                val[i] = 1'b1;
            end
        end
        return val;
    endfunction

    function automatic void apply_store(input lsu_pkg::mem_op_e op,
                                        input logic [XLEN-1:0] addr,
                                        input logic [XLEN-1:0] data);
        int n;
        int base;
        n    = 1 << op[1:0];
        base = int'(addr[AW-1:0]);
        for (int i = 0; i < n; i++) begin
            shadow[base + i] = data[i*8 +: 8];
        end
    endfunction

    // one request with an optional second start while busy
    task automatic run_access(input logic we, input lsu_pkg::mem_op_e op,
                              input logic [XLEN-1:0] addr, input logic [XLEN-1:0] wdata,
                              input logic poke);
        logic            bad;
        logic [XLEN-1:0] exp_data;
        int              cycles;
        bad      = access_illegal(we, op, addr);
        exp_data = expect_load(op, addr);
        @(negedge clk);
        // previous request fully drained
        assert (!busy_o) else begin
            $display("FAIL busy_o: got %h, expected %h before start, addr %h",
                     busy_o, 1'b0, addr);
            test_errs++;
        end
        start_i = 1'b1;
        we_i    = we;
        op_i    = op;
        addr_i  = addr;
        wdata_i = wdata;
        @(negedge clk);
        start_i = poke;
        if (poke) begin
            // this one must be dropped
            we_i    = 1'b1;
            op_i    = lsu_pkg::MEM_D;
            addr_i  = addr ^ 64'h40;
            wdata_i = ~wdata;
        end
        cycles = 0;
        while (!done_o && cycles < 20) begin
            assert (busy_o) else begin
                $display("FAIL busy_o: got %h, expected %h while waiting, addr %h",
                         busy_o, 1'b1, addr);
                test_errs++;
            end
            @(negedge clk);
            start_i = 1'b0;
            cycles++;
        end
        if (!done_o) begin
            $display("timeout: done_o never rose for the request at address %h", addr);
            test_errs++;
        end else begin
            assert (busy_o) else begin
                $display("FAIL busy_o: got %h, expected %h with done_o, addr %h",
                         busy_o, 1'b1, addr);
                test_errs++;
            end
            assert (err_o == bad) else begin
                $display("FAIL err_o: got %h, expected %h, addr %h", err_o, bad, addr);
                test_errs++;
            end
            if (!we && !bad) begin
                assert (rdata_o == exp_data) else begin
                    $display("FAIL rdata_o: got %h, expected %h, op %h, addr %h",
                             rdata_o, exp_data, op, addr);
                    test_errs++;
                end
            end
            if (we && !bad) begin
                apply_store(op, addr, wdata);
            end
        end
    endtask

    task automatic close_test(input string name);
        if (test_errs == 0) begin
            $display("test %s: ok", name);
            tests_ok++;
        end else begin
            $display("test %s: %0d errors", name, test_errs);
            tests_bad++;
        end
        total_errs += test_errs;
        test_errs = 0;
    endtask

    task automatic dword_roundtrip();
        logic [XLEN-1:0] addrs [5];
        // the last one wraps onto 0x008
        addrs = '{64'h0, 64'h8, 64'h100, 64'h7f8, 64'h808};
        for (int i = 0; i < 5; i++) begin
            run_access(1'b1, lsu_pkg::MEM_D, addrs[i], {$urandom, $urandom}, 1'b0);
        end
        for (int i = 0; i < 5; i++) begin
            run_access(1'b0, lsu_pkg::MEM_D, addrs[i], '0, 1'b0);
        end
        close_test("dword_roundtrip");
    endtask

    task automatic lane_writes();
        for (int sz = 0; sz < 3; sz++) begin
            for (int off = 0; off < 8; off += (1 << sz)) begin
                run_access(1'b1, lsu_pkg::mem_op_e'(3'(sz)), 64'h40 + 64'(off),
                           {$urandom, $urandom}, 1'b0);
                run_access(1'b0, lsu_pkg::MEM_D, 64'h40, '0, 1'b0);
            end
        end
        close_test("lane_writes");
    endtask

    task automatic load_extension();
        logic [XLEN-1:0] pats [2];
        // every lane negative and then every lane positive
        pats = '{64'hf1e2_d3c4_b5a6_9788, 64'h7162_5344_3526_1708};
        for (int p = 0; p < 2; p++) begin
            run_access(1'b1, lsu_pkg::MEM_D, 64'h80, pats[p], 1'b0);
            for (int op = 0; op < 7; op++) begin
                for (int off = 0; off < 8; off += (1 << (op % 4))) begin
                    run_access(1'b0, lsu_pkg::mem_op_e'(3'(op)), 64'h80 + 64'(off), '0, 1'b0);
                end
            end
        end
        close_test("load_extension");
    endtask

    task automatic misaligned_requests();
        run_access(1'b1, lsu_pkg::MEM_D, 64'hc0, 64'h1122_3344_5566_7788, 1'b0);
        run_access(1'b0, lsu_pkg::MEM_H, 64'hc1, '0, 1'b0);
        run_access(1'b0, lsu_pkg::MEM_WU, 64'hc2, '0, 1'b0);
        run_access(1'b0, lsu_pkg::MEM_D, 64'hc4, '0, 1'b0);
        run_access(1'b1, lsu_pkg::MEM_H, 64'hc3, '1, 1'b0);
        run_access(1'b1, lsu_pkg::MEM_W, 64'hc6, '1, 1'b0);
        run_access(1'b1, lsu_pkg::MEM_D, 64'hc1, '1, 1'b0);
        // aligned but store with a zero-extend op
        run_access(1'b1, lsu_pkg::MEM_BU, 64'hc0, '1, 1'b0);
        run_access(1'b1, lsu_pkg::MEM_HU, 64'hc0, '1, 1'b0);
        run_access(1'b1, lsu_pkg::MEM_WU, 64'hc4, '1, 1'b0);
        run_access(1'b0, lsu_pkg::MEM_D, 64'hc0, '0, 1'b0);
        close_test("misaligned_requests");
    endtask

    task automatic start_while_busy();
        run_access(1'b1, lsu_pkg::MEM_D, 64'h200, 64'hdead_beef_0bad_f00d, 1'b1);
        run_access(1'b0, lsu_pkg::MEM_D, 64'h200, '0, 1'b0);
        run_access(1'b0, lsu_pkg::MEM_D, 64'h240, '0, 1'b0);
        close_test("start_while_busy");
    endtask

    task automatic random_traffic();
        logic             we;
        lsu_pkg::mem_op_e op;
        logic [XLEN-1:0]  addr;
        for (int i = 0; i < 200; i++) begin
            we = 1'($urandom_range(1, 0));
            op = lsu_pkg::mem_op_e'(3'($urandom_range(6, 0)));
            if (we) begin
                op = lsu_pkg::mem_op_e'({1'b0, op[1:0]});
            end
            // twice the depth so the wrap is used
            addr = {52'b0, 12'($urandom_range(4095, 0))};
            addr = addr & ~((64'd1 << op[1:0]) - 64'd1);
            run_access(we, op, addr, {$urandom, $urandom}, 1'b0);
        end
        close_test("random_traffic");
    endtask

    initial begin
        void'($urandom(32'h3e64_bb79));
        rst_i      = 1'b1;
        start_i    = 1'b0;
        we_i       = 1'b0;
        op_i       = lsu_pkg::MEM_D;
        addr_i     = '0;
        wdata_i    = '0;
        test_errs  = 0;
        total_errs = 0;
        tests_ok   = 0;
        tests_bad  = 0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            shadow[i] = 8'h00;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        dword_roundtrip();
        lane_writes();
        load_extension();
        misaligned_requests();
        start_while_busy();
        random_traffic();
        $display("summary: %0d tests ok, %0d tests failed, %0d errors",
                 tests_ok, tests_bad, total_errs);
        if (total_errs == 0 && tests_bad == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* testbench/ls_unit_props.sv */
`timescale 1ns/100ps

module ls_unit_props (
    input logic       clk,
    input logic       rst_i,
    input logic       start_i,
    input logic       we_i,
    input logic [2:0] op_i,
    input logic [2:0] off_i,
    input logic       busy_i,
    input logic       done_i,
    input logic       err_i,
    input logic       rd_en_i,
    input logic       wr_en_i,
    input logic       rd_valid_i,
    input logic       wr_ok_i
);

    logic       accepted;
    logic       misaligned;
    // offset bits that must be zero for the access width
    logic [2:0] low_bits;

    always_comb begin
        case (op_i[1:0])
            2'd0:    low_bits = 3'b000;
            2'd1:    low_bits = 3'b001;
            2'd2:    low_bits = 3'b011;
            default: low_bits = 3'b111;
        endcase
    end

    assign accepted   = start_i && !busy_i;
    assign misaligned = (|(off_i & low_bits)) || (we_i && op_i[2]) || (op_i == 3'd7);

    // legal request, done four sampling edges after the start is taken
    a_latency: assert property (@(posedge clk) disable iff (rst_i)
        $past(accepted && !misaligned, 4) |-> done_i && !err_i)
        else $error("done_o missing three cycles after a legal start");

    a_no_early_done: assert property (@(posedge clk) disable iff (rst_i)
        $past(accepted, 1) || $past(accepted && !misaligned, 2) ||
        $past(accepted && !misaligned, 3) |-> !done_i)
        else $error("done_o raised too early");

    // error path skips the sram
    a_err_latency: assert property (@(posedge clk) disable iff (rst_i)
        $past(accepted && misaligned, 2) |-> done_i && err_i)
        else $error("err_o missing one cycle after a misaligned start");

    a_no_enable: assert property (@(posedge clk) disable iff (rst_i)
        $past(accepted && misaligned, 1) || $past(accepted && misaligned, 2) |->
        !rd_en_i && !wr_en_i)
        else $error("sram enable raised for a misaligned request");

    // enables are single-cycle strobes
    a_rd_pulse: assert property (@(posedge clk) disable iff (rst_i)
        $past(rd_en_i) |-> !rd_en_i)
        else $error("sram read enable held longer than one cycle");

    a_wr_pulse: assert property (@(posedge clk) disable iff (rst_i)
        $past(wr_en_i) |-> !wr_en_i)
        else $error("sram write enable held longer than one cycle");

    a_reset: assert property (@(posedge clk)
        $past(rst_i) |-> !busy_i && !done_i && !err_i && !rd_en_i && !wr_en_i &&
        !rd_valid_i && !wr_ok_i)
        else $error("outputs not cleared by reset");

endmodule

bind ls_unit_top ls_unit_props ls_unit_props_i (
    .clk        (clk),
    .rst_i      (rst_i),
    .start_i    (start_i),
    .we_i       (we_i),
    .op_i       (op_i),
    .off_i      (addr_i[2:0]),
    .busy_i     (busy_o),
    .done_i     (done_o),
    .err_i      (err_o),
    .rd_en_i    (ls_sram_rd_en),
    .wr_en_i    (ls_sram_wr_en),
    .rd_valid_i (ls_sram_rd_data_valid),
    .wr_ok_i    (ls_sram_wr_data_ok)
);

/* rtl/ls_unit_top.sv */
`timescale 1ns/100ps

module ls_unit_top #(
    parameter int SRAM_DEPTH = 256
) (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     start_i,
    input  logic                     we_i,
    input  lsu_pkg::mem_op_e         op_i,
    input  logic [lsu_pkg::XLEN-1:0] addr_i,
    input  logic [lsu_pkg::XLEN-1:0] wdata_i,

    output logic                     busy_o,
    output logic                     done_o,
    output logic                     err_o,
    output logic [lsu_pkg::XLEN-1:0] rdata_o
);

    // controller to lsu
    logic                     rden;
    logic                     wren;
    lsu_pkg::mem_op_e         op;
    logic [lsu_pkg::XLEN-1:0] addr;
    logic [lsu_pkg::XLEN-1:0] wdata;
    // lsu back to controller
    logic                     rd_done;
    logic                     wr_done;
    logic [lsu_pkg::XLEN-1:0] res;

    // sram port
    logic [lsu_pkg::XLEN-1:0] ls_sram_addr;
    logic                     ls_sram_rd_en;
    logic                     ls_sram_wr_en;
    logic [lsu_pkg::XLEN-1:0] ls_sram_wr_data;
    logic [7:0]               ls_sram_wr_mask;
    logic [2:0]               ls_sram_wr_size;
    logic [2:0]               ls_sram_rd_size;
    logic                     ls_sram_rd_data_valid;
    logic                     ls_sram_wr_data_ok;
    logic [lsu_pkg::XLEN-1:0] ls_sram_rd_data;

    ls_ctrl ls_ctrl_i (
        .clk       (clk),
        .rst_i     (rst_i),
        .start_i   (start_i),
        .we_i      (we_i),
        .op_i      (op_i),
        .addr_i    (addr_i),
        .wdata_i   (wdata_i),
        .rd_done_i (rd_done),
        .wr_done_i (wr_done),
        .res_i     (res),
        .rden_o    (rden),
        .wren_o    (wren),
        .op_o      (op),
        .addr_o    (addr),
        .wdata_o   (wdata),
        .busy_o    (busy_o),
        .done_o    (done_o),
        .err_o     (err_o),
        .rdata_o   (rdata_o)
    );

    lsu lsu_i (
        .clk                     (clk),
        .rst_i                   (rst_i),
        .wren_i                  (wren),
        .rden_i                  (rden),
        .memop_i                 (op),
        .wr_data_i               (wdata),
        .addr_i                  (addr),
        .ls_sram_rd_data_valid_i (ls_sram_rd_data_valid),
        .ls_sram_wr_data_ok_i    (ls_sram_wr_data_ok),
        .ls_sram_rd_data_i       (ls_sram_rd_data),
        .ls_res_o                (res),
        .ls_rd_done_o            (rd_done),
        .ls_wr_done_o            (wr_done),
        .ls_sram_addr_o          (ls_sram_addr),
        .ls_sram_rd_en_o         (ls_sram_rd_en),
        .ls_sram_wr_en_o         (ls_sram_wr_en),
        .ls_sram_wr_data_o       (ls_sram_wr_data),
        .ls_sram_wr_mask_o       (ls_sram_wr_mask),
        .ls_sram_wr_size_o       (ls_sram_wr_size),
        .ls_sram_rd_size_o       (ls_sram_rd_size)
    );

    data_sram #(
        .SRAM_DEPTH (SRAM_DEPTH)
    ) data_sram_i (
        .clk             (clk),
        .rst_i           (rst_i),
        .addr_i          (ls_sram_addr),
        .rd_en_i         (ls_sram_rd_en),
        .wr_en_i         (ls_sram_wr_en),
        .wr_data_i       (ls_sram_wr_data),
        .wr_mask_i       (ls_sram_wr_mask),
        .wr_size_i       (ls_sram_wr_size),
        .rd_size_i       (ls_sram_rd_size),
        .rd_data_valid_o (ls_sram_rd_data_valid),
        .wr_data_ok_o    (ls_sram_wr_data_ok),
        .rd_data_o       (ls_sram_rd_data)
    );

endmodule

/* rtl/data_sram.sv */
`timescale 1ns/100ps

module data_sram #(
    parameter int SRAM_DEPTH = 256
) (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic [lsu_pkg::XLEN-1:0] addr_i,
    input  logic                     rd_en_i,
    input  logic                     wr_en_i,
    input  logic [lsu_pkg::XLEN-1:0] wr_data_i,
    input  logic [7:0]               wr_mask_i,
    input  logic [2:0]               wr_size_i,
    // reads always return the full doubleword
    input  logic [2:0]               rd_size_i,

    output logic                     rd_data_valid_o,
    output logic                     wr_data_ok_o,
    output logic [lsu_pkg::XLEN-1:0] rd_data_o
);

    localparam int IDX_W = $clog2(SRAM_DEPTH);

    logic [lsu_pkg::XLEN-1:0] mem [SRAM_DEPTH];
    // doubleword index, upper address bits wrap
    logic [IDX_W-1:0]         idx;
    logic [7:0]               size_mask;
    logic [7:0]               lane_mask;
    logic [lsu_pkg::XLEN-1:0] lane_data;

    assign idx = addr_i[IDX_W+2:3];

    // caps the byte mask at the access size
    always_comb begin
        unique case (wr_size_i)
            3'd0:    size_mask = 8'h01;
            3'd1:    size_mask = 8'h03;
            3'd2:    size_mask = 8'h0f;
            default: size_mask = 8'hff;
        endcase
    end

    // move mask and data up into the addressed lanes
    assign lane_mask = (wr_mask_i & size_mask) << addr_i[2:0];
    assign lane_data = wr_data_i << {addr_i[2:0], 3'b000};

    // contents start at zero
    initial begin
        for (int i = 0; i < SRAM_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            for (int b = 0; b < 8; b++) begin
                if (lane_mask[b]) begin
                    mem[idx][b*8 +: 8] <= lane_data[b*8 +: 8];
                end
            end
        end
        if (rd_en_i) begin
            rd_data_o <= mem[idx];
        end
    end

    // one-cycle response pulses
    always_ff @(posedge clk) begin
        if (rst_i) begin
            rd_data_valid_o <= 1'b0;
            wr_data_ok_o    <= 1'b0;
        end else begin
            rd_data_valid_o <= rd_en_i;
            wr_data_ok_o    <= wr_en_i;
        end
    end

endmodule

/* rtl/ls_ctrl.sv */
`timescale 1ns/100ps

module ls_ctrl (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     start_i,
    input  logic                     we_i,
    input  lsu_pkg::mem_op_e         op_i,
    input  logic [lsu_pkg::XLEN-1:0] addr_i,
    input  logic [lsu_pkg::XLEN-1:0] wdata_i,
    input  logic                     rd_done_i,
    input  logic                     wr_done_i,
    input  logic [lsu_pkg::XLEN-1:0] res_i,

    output logic                     rden_o,
    output logic                     wren_o,
    output lsu_pkg::mem_op_e         op_o,
    output logic [lsu_pkg::XLEN-1:0] addr_o,
    output logic [lsu_pkg::XLEN-1:0] wdata_o,
    output logic                     busy_o,
    output logic                     done_o,
    output logic                     err_o,
    output logic [lsu_pkg::XLEN-1:0] rdata_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ISSUE,
        S_WAIT,
        S_DONE
    } ctrl_state_e;

    ctrl_state_e state_q;
    logic        accept;
    logic        bad_req;
    logic        err_q;
    logic        we_q;

    // misaligned for its size, store with a zero-extend op, or an unknown op
    function automatic logic req_illegal(input lsu_pkg::mem_op_e op, input logic we,
                                         input logic [2:0] off);
        logic bad;
        bad = 1'b0;
        case (op)
            lsu_pkg::MEM_B, lsu_pkg::MEM_BU: bad = 1'b0;
            lsu_pkg::MEM_H, lsu_pkg::MEM_HU: bad = off[0];
            lsu_pkg::MEM_W, lsu_pkg::MEM_WU: bad = |off[1:0];
            lsu_pkg::MEM_D:                  bad = |off;
            default:                         bad = 1'b1;
        endcase
        if (we && op[2]) begin
            bad = 1'b1;
        end
        return bad;
    endfunction

    // stays busy through the done pulse
    assign busy_o  = (state_q != S_IDLE) || done_o;
    assign accept  = start_i && !busy_o;
    assign bad_req = req_illegal(op_i, we_i, addr_i[2:0]);

    // one-cycle strobe while in ISSUE
    assign rden_o = (state_q == S_ISSUE) && !we_q;
    assign wren_o = (state_q == S_ISSUE) && we_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= S_IDLE;
            err_q   <= 1'b0;
            done_o  <= 1'b0;
            err_o   <= 1'b0;
        end else begin
            // done and err are registered off the DONE state
            done_o <= (state_q == S_DONE);
            err_o  <= (state_q == S_DONE) && err_q;
            unique case (state_q)
                S_IDLE: begin
                    if (accept) begin
                        err_q   <= bad_req;
                        // an illegal request skips the sram entirely
                        state_q <= bad_req ? S_DONE : S_ISSUE;
                    end
                end
                S_ISSUE: state_q <= S_WAIT;
                S_WAIT: begin
                    if (rd_done_i || wr_done_i) begin
                        state_q <= S_DONE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // request held for the whole transaction
    always_ff @(posedge clk) begin
        if (accept) begin
            we_q    <= we_i;
            op_o    <= op_i;
            addr_o  <= addr_i;
            wdata_o <= wdata_i;
            rdata_o <= '0;
        end else if (state_q == S_WAIT && rd_done_i) begin
            rdata_o <= res_i;
        end
    end

endmodule

/* rtl/lsu.sv */
`timescale 1ns/100ps

module lsu (
    // clock and reset of the memory stage, the block itself is combinational
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     wren_i,
    input  logic                     rden_i,
    input  lsu_pkg::mem_op_e         memop_i,
    input  logic [lsu_pkg::XLEN-1:0] wr_data_i,
    input  logic [lsu_pkg::XLEN-1:0] addr_i,
    input  logic                     ls_sram_rd_data_valid_i,
    input  logic                     ls_sram_wr_data_ok_i,
    input  logic [lsu_pkg::XLEN-1:0] ls_sram_rd_data_i,

    output logic [lsu_pkg::XLEN-1:0] ls_res_o,
    output logic                     ls_rd_done_o,
    output logic                     ls_wr_done_o,

    output logic [lsu_pkg::XLEN-1:0] ls_sram_addr_o,
    output logic                     ls_sram_rd_en_o,
    output logic                     ls_sram_wr_en_o,
    output logic [lsu_pkg::XLEN-1:0] ls_sram_wr_data_o,
    output logic [7:0]               ls_sram_wr_mask_o,
    output logic [2:0]               ls_sram_wr_size_o,
    output logic [2:0]               ls_sram_rd_size_o
);

    // width flags decoded from the op alone
    logic       is_byte;
    logic       is_half;
    logic       is_word;
    logic       is_dword;
    logic       is_zext;
    // lane size code, 0 byte up to 3 doubleword
    logic [2:0] lane_size;
    // store ops with the extension bit set are not stores
    logic       st_legal;
    logic [7:0] wr_mask;

    // lanes picked out of the returned doubleword
    logic [7:0]  rd_b;
    logic [15:0] rd_h;
    logic [31:0] rd_w;

    always_comb begin
        is_byte  = 1'b0;
        is_half  = 1'b0;
        is_word  = 1'b0;
        is_dword = 1'b0;
        unique case (memop_i)
            lsu_pkg::MEM_B, lsu_pkg::MEM_BU: is_byte  = 1'b1;
            lsu_pkg::MEM_H, lsu_pkg::MEM_HU: is_half  = 1'b1;
            lsu_pkg::MEM_W, lsu_pkg::MEM_WU: is_word  = 1'b1;
            lsu_pkg::MEM_D:                  is_dword = 1'b1;
            default:                         is_byte  = 1'b0;
        endcase
    end

    assign is_zext   = (memop_i == lsu_pkg::MEM_BU) || (memop_i == lsu_pkg::MEM_HU) ||
                       (memop_i == lsu_pkg::MEM_WU);
    assign lane_size = {1'b0, is_word | is_dword, is_half | is_dword};
    assign st_legal  = (is_byte | is_half | is_word | is_dword) & ~is_zext;

    // unshifted mask, the sram moves it into the addressed lanes
    always_comb begin
        wr_mask = 8'h00;
        if (wren_i && st_legal) begin
            unique case (lane_size)
                3'd0:    wr_mask = 8'b0000_0001;
                3'd1:    wr_mask = 8'b0000_0011;
                3'd2:    wr_mask = 8'b0000_1111;
                default: wr_mask = 8'b1111_1111;
            endcase
        end
    end

    // sram port
    assign ls_sram_addr_o    = addr_i;
    assign ls_sram_rd_en_o   = rden_i;
    assign ls_sram_wr_en_o   = wren_i;
    assign ls_sram_wr_data_o = wr_data_i;
    assign ls_sram_wr_mask_o = wr_mask;
    assign ls_sram_wr_size_o = (wren_i && st_legal) ? lane_size : 3'd0;
    assign ls_sram_rd_size_o = rden_i ? lane_size : 3'd0;

    // response strobes go straight back to the controller
    assign ls_rd_done_o = ls_sram_rd_data_valid_i;
    assign ls_wr_done_o = ls_sram_wr_data_ok_i;

    // aligned lane select, misaligned requests never reach here
    assign rd_b = ls_sram_rd_data_i[{addr_i[2:0], 3'b000} +: 8];
    assign rd_h = ls_sram_rd_data_i[{addr_i[2:1], 4'b0000} +: 16];
    assign rd_w = ls_sram_rd_data_i[{addr_i[2], 5'b00000} +: 32];

    // response arrives the cycle after the strobe, so the op alone selects
    always_comb begin
        ls_res_o = '0;
        if (ls_sram_rd_data_valid_i) begin
            unique case (memop_i)
                lsu_pkg::MEM_B:  ls_res_o = {{56{rd_b[7]}}, rd_b};
                lsu_pkg::MEM_BU: ls_res_o = {56'b0, rd_b};
                lsu_pkg::MEM_H:  ls_res_o = {{48{rd_h[15]}}, rd_h};
                lsu_pkg::MEM_HU: ls_res_o = {48'b0, rd_h};
                lsu_pkg::MEM_W:  ls_res_o = {{32{rd_w[31]}}, rd_w};
                lsu_pkg::MEM_WU: ls_res_o = {32'b0, rd_w};
                lsu_pkg::MEM_D:  ls_res_o = ls_sram_rd_data_i;
                default:         ls_res_o = '0;
            endcase
        end
    end

endmodule

/* rtl/lsu_pkg.sv */
package lsu_pkg;

    // data path and address width of the core
    localparam int XLEN = 64;

    // memory op, encoded as the load/store funct3 field
    // bit 2 marks the zero-extending loads
    // bits 1:0 give the access width
    typedef enum logic [2:0] {
        // byte, sign extended on load
        MEM_B  = 3'd0,
        // halfword, sign extended on load
        MEM_H  = 3'd1,
        // word, sign extended on load
        MEM_W  = 3'd2,
        // doubleword, no extension needed
        MEM_D  = 3'd3,
        // byte, zero extended
        MEM_BU = 3'd4,
        // halfword, zero extended
        MEM_HU = 3'd5,
        // word, zero extended
        MEM_WU = 3'd6
    } mem_op_e;

    // stores only use MEM_B through MEM_D
    // 3'd7 is never a legal op

endpackage
